// File: logic/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// data path and register file size
`define XLEN      32
`define REG_COUNT 32

// matching cycles of the success value before the run stops
`define SUCCESS_HOLD_CYCLES 30

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

// opcodes of the supported instructions
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_STORE  7'b0100011

`endif

// File: logic/rv_isa_pkg.sv
`include "rv_core_defines.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
    typedef logic [31:0] instr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // operations the core knows, everything else is a nop
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_ADDI,
        OP_LUI,
        OP_STORE
    } alu_op_e;

endpackage

// File: logic/rv_mem_pkg.sv
package rv_mem_pkg;

    // byte address on both memory ports
    typedef logic [31:0] mem_addr_t;
    typedef logic [3:0] byte_en_t;

    // bit 0 start, bit 1 soft reset
    typedef logic [31:0] ctrl_word_t;

    typedef enum logic [1:0] {
        IDLE,
        RUNNING,
        STOPPED
    } run_state_e;

endpackage

// File: logic/rv_decode.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_decode import rv_isa_pkg::*; (
    input  instr_t   instr_i,
    output reg_idx_t rd_o,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output funct3_t  funct3_o,
    output word_t    imm_o,
    output alu_op_e  op_o,
    output logic     writes_rd_o
);
    opcode_t    opcode;
    logic [6:0] funct7;

    assign opcode   = instr_i[6:0];
    assign funct7   = instr_i[31:25];
    assign rd_o     = instr_i[11:7];
    assign funct3_o = instr_i[14:12];
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];

    always_comb begin
        op_o  = OP_NOP;
        imm_o = '0;
        case (opcode)
            `OPC_OP: begin
                if (funct3_o == 3'b000 && funct7 == 7'b0000000) begin
                    op_o = OP_ADD;
                end else if (funct3_o == 3'b000 && funct7 == 7'b0100000) begin
                    op_o = OP_SUB;
                end
            end
            `OPC_OP_IMM: begin
                if (funct3_o == 3'b000) begin
                    op_o  = OP_ADDI;
                    imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
                end
            end
            `OPC_LUI: begin
                op_o  = OP_LUI;
                imm_o = {instr_i[31:12], 12'b0};
            end
            `OPC_STORE: begin
                // sb, sh, sw only
                if (funct3_o <= 3'b010) begin
                    op_o  = OP_STORE;
                    imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                end
            end
            default: begin
                op_o = OP_NOP;
            end
        endcase
    end

    assign writes_rd_o = (op_o inside {OP_ADD, OP_SUB, OP_ADDI, OP_LUI}) && (rd_o != '0);

endmodule

// File: logic/rv_reg_file.sv
`timescale 1ns/1ps

module rv_reg_file import rv_isa_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  logic     we_i,
    input  reg_idx_t rd_i,
    input  word_t    wdata_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);
    word_t regs_q [1 << $bits(reg_idx_t)];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << $bits(reg_idx_t)); i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // write data bypasses the array in the same cycle
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (we_i && rd_i == rs1_i) ? wdata_i : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (we_i && rd_i == rs2_i) ? wdata_i : regs_q[rs2_i];

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core import rv_isa_pkg::*, rv_mem_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      enable_i,
    input  logic      clear_i,
    input  logic      start_i,
    input  mem_addr_t initial_pc_i,
    input  mem_addr_t memory_offset_i,
    input  logic      fetch_gnt_i,
    input  logic      fetch_rvalid_i,
    input  instr_t    fetch_rdata_i,
    output logic      fetch_req_o,
    output mem_addr_t fetch_addr_o,
    output word_t     final_value_o,
    output logic      data_mem_clk_o,
    output logic      data_mem_en_o,
    output byte_en_t  data_mem_we_o,
    output mem_addr_t data_mem_addr_o,
    output word_t     data_mem_din_o
);
    logic      advance;
    mem_addr_t pc_q;
    logic      skid_valid_q;
    instr_t    skid_instr_q;
    logic      fetch_valid;
    instr_t    fetch_instr;

    // id stage
    instr_t   id_instr_q;
    reg_idx_t dec_rd, dec_rs1, dec_rs2;
    funct3_t  dec_funct3;
    word_t    dec_imm, rf_rs1_data, rf_rs2_data;
    alu_op_e  dec_op;
    logic     dec_writes_rd;

    // ex stage
    alu_op_e  ex_op_q;
    logic     ex_writes_rd_q;
    reg_idx_t ex_rd_q, ex_rs1_q, ex_rs2_q;
    word_t    ex_rs1_data_q, ex_rs2_data_q, ex_imm_q;
    funct3_t  ex_funct3_q;
    word_t    op_a, op_b, alu_result;

    // mem stage
    logic      mem_is_store_q, mem_writes_rd_q;
    reg_idx_t  mem_rd_q;
    word_t     mem_result_q, mem_store_data_q;
    funct3_t   mem_funct3_q;
    mem_addr_t store_addr;
    byte_en_t  store_be;
    word_t     store_din;

    // wb stage
    logic      wb_we_q, wb_store_q;
    reg_idx_t  wb_rd_q;
    word_t     wb_result_q, wb_din_q, final_value_q;
    byte_en_t  wb_be_q;
    mem_addr_t wb_addr_q;

    assign advance     = enable_i && !clear_i;
    assign fetch_req_o = advance;
    assign fetch_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= '0;
        end else if (start_i) begin
            pc_q <= initial_pc_i;
        end else if (fetch_req_o && fetch_gnt_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // a word that returns while frozen waits in the skid register
    assign fetch_valid = skid_valid_q || fetch_rvalid_i;
    assign fetch_instr = skid_valid_q ? skid_instr_q : fetch_rdata_i;

    rv_decode i_decode (
        .instr_i     (id_instr_q),
        .rd_o        (dec_rd),
        .rs1_o       (dec_rs1),
        .rs2_o       (dec_rs2),
        .funct3_o    (dec_funct3),
        .imm_o       (dec_imm),
        .op_o        (dec_op),
        .writes_rd_o (dec_writes_rd)
    );

    rv_reg_file i_reg_file (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (dec_rs1),
        .rs2_i      (dec_rs2),
        .we_i       (wb_we_q && advance),
        .rd_i       (wb_rd_q),
        .wdata_i    (wb_result_q),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data)
    );

    // newest producer wins, mem before wb
    function automatic word_t forward(reg_idx_t rs, word_t rf_value);
        if (rs == '0) begin
            return rf_value;
        end else if (mem_writes_rd_q && mem_rd_q == rs) begin
            return mem_result_q;
        end else if (wb_we_q && wb_rd_q == rs) begin
            return wb_result_q;
        end
        return rf_value;
    endfunction

    always_comb begin
        op_a = forward(ex_rs1_q, ex_rs1_data_q);
        op_b = forward(ex_rs2_q, ex_rs2_data_q);
        case (ex_op_q)
            OP_ADD:            alu_result = op_a + op_b;
            OP_SUB:            alu_result = op_a - op_b;
            OP_ADDI, OP_STORE: alu_result = op_a + ex_imm_q;
            OP_LUI:            alu_result = ex_imm_q;
            default:           alu_result = '0;
        endcase
    end

    // lane placement from the low address bits
    always_comb begin
        store_addr = mem_result_q - memory_offset_i;
        case (mem_funct3_q)
            3'b000: begin
                store_be  = 4'b0001 << store_addr[1:0];
                store_din = {4{mem_store_data_q[7:0]}};
            end
            3'b001: begin
                store_be  = store_addr[1] ? 4'b1100 : 4'b0011;
                store_din = {2{mem_store_data_q[15:0]}};
            end
            default: begin
                store_be  = 4'b1111;
                store_din = mem_store_data_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || clear_i) begin
            skid_valid_q    <= 1'b0;
            id_instr_q      <= `NOP_INSTR;
            ex_op_q         <= OP_NOP;
            ex_writes_rd_q  <= 1'b0;
            mem_is_store_q  <= 1'b0;
            mem_writes_rd_q <= 1'b0;
            wb_we_q         <= 1'b0;
            wb_store_q      <= 1'b0;
            final_value_q   <= '0;
        end else if (enable_i) begin
            skid_valid_q    <= 1'b0;
            id_instr_q      <= fetch_valid ? fetch_instr : `NOP_INSTR;
            ex_op_q         <= dec_op;
            ex_writes_rd_q  <= dec_writes_rd;
            mem_is_store_q  <= (ex_op_q == OP_STORE);
            mem_writes_rd_q <= ex_writes_rd_q;
            wb_we_q         <= mem_writes_rd_q;
            wb_store_q      <= mem_is_store_q;
            if (mem_is_store_q) begin
                final_value_q <= mem_store_data_q;
            end
        end else if (fetch_rvalid_i) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!enable_i && fetch_rvalid_i) begin
            skid_instr_q <= fetch_rdata_i;
        end
        if (enable_i) begin
            ex_rd_q          <= dec_rd;
            ex_rs1_q         <= dec_rs1;
            ex_rs2_q         <= dec_rs2;
            ex_rs1_data_q    <= rf_rs1_data;
            ex_rs2_data_q    <= rf_rs2_data;
            ex_imm_q         <= dec_imm;
            ex_funct3_q      <= dec_funct3;
            mem_rd_q         <= ex_rd_q;
            mem_result_q     <= alu_result;
            mem_store_data_q <= op_b;
            mem_funct3_q     <= ex_funct3_q;
            wb_rd_q          <= mem_rd_q;
            wb_result_q      <= mem_result_q;
            wb_be_q          <= store_be;
            wb_addr_q        <= {store_addr[31:2], 2'b00};
            wb_din_q         <= store_din;
        end
    end

    // a held store goes out once, in the cycle it leaves wb
    assign data_mem_clk_o  = clk;
    assign data_mem_en_o   = wb_store_q && advance;
    assign data_mem_we_o   = data_mem_en_o ? wb_be_q : 4'b0000;
    assign data_mem_addr_o = wb_addr_q;
    assign data_mem_din_o  = wb_din_q;
    assign final_value_o   = final_value_q;

endmodule

// File: logic/run_ctrl.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module run_ctrl import rv_mem_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  ctrl_word_t       ctrl_i,
    input  mem_addr_t        initial_pc_i,
    input  logic [`XLEN-1:0] success_code_i,
    input  logic [`XLEN-1:0] final_value_i,
    output logic             core_enable_o,
    output logic             core_clear_o,
    output logic             start_o,
    output mem_addr_t        initial_pc_o,
    output logic             stop_o
);
    ctrl_word_t ctrl_prev_q;
    ctrl_word_t ctrl_rise_q;
    run_state_e state_q;
    mem_addr_t  initial_pc_q;
    logic [$clog2(`SUCCESS_HOLD_CYCLES + 1)-1:0] match_count_q;

    // one cycle pulse per rising bit
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_prev_q <= '0;
            ctrl_rise_q <= '0;
        end else begin
            ctrl_prev_q <= ctrl_i;
            ctrl_rise_q <= ctrl_i & ~ctrl_prev_q;
        end
    end

    // latched together with the start pulse
    always_ff @(posedge clk) begin
        if (ctrl_i[0] && !ctrl_prev_q[0]) begin
            initial_pc_q <= initial_pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl_rise_q[1]) begin
            state_q       <= IDLE;
            match_count_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ctrl_rise_q[0]) begin
                        state_q       <= RUNNING;
                        match_count_q <= '0;
                    end
                end
                RUNNING: begin
                    if (match_count_q == `SUCCESS_HOLD_CYCLES) begin
                        state_q <= STOPPED;
                    end else if (final_value_i == success_code_i) begin
                        match_count_q <= match_count_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= STOPPED;
                end
            endcase
        end
    end

    // start only counts from idle
    assign start_o       = ctrl_rise_q[0] && (state_q == IDLE);
    assign core_clear_o  = ctrl_rise_q[1];
    assign core_enable_o = (state_q == RUNNING);
    assign stop_o        = (state_q == STOPPED);
    assign initial_pc_o  = initial_pc_q;

endmodule

// File: logic/imem_bram_adapter.sv
`timescale 1ns/1ps

module imem_bram_adapter import rv_mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch_req_i,
    input  mem_addr_t   fetch_addr_i,
    input  logic [31:0] ins_mem_dout_i,
    output logic        fetch_gnt_o,
    output logic        fetch_rvalid_o,
    output logic [31:0] fetch_rdata_o,
    output logic        ins_mem_clk_o,
    output logic        ins_mem_en_o,
    output mem_addr_t   ins_mem_addr_o
);
    logic read_pending_q;

    // bram takes a read every cycle
    assign fetch_gnt_o    = fetch_req_i;
    assign ins_mem_clk_o  = clk;
    assign ins_mem_en_o   = fetch_req_i;
    assign ins_mem_addr_o = fetch_addr_i;

    // word shows up one cycle after the granted read
    always_ff @(posedge clk) begin
        if (reset) begin
            read_pending_q <= 1'b0;
        end else begin
            read_pending_q <= fetch_req_i;
        end
    end

    assign fetch_rvalid_o = read_pending_q;
    assign fetch_rdata_o  = ins_mem_dout_i;

endmodule

// File: logic/rv_soc_top.sv
`timescale 1ns/1ps

module rv_soc_top import rv_mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  ctrl_word_t  ctrl_i,
    input  mem_addr_t   memory_offset_i,
    input  mem_addr_t   initial_pc_i,
    input  logic [31:0] success_code_i,
    output logic        stop_o,

    output logic        ins_mem_clk_o,
    output logic        ins_mem_en_o,
    output mem_addr_t   ins_mem_addr_o,
    input  logic [31:0] ins_mem_dout_i,

    output logic        data_mem_clk_o,
    output logic        data_mem_en_o,
    output byte_en_t    data_mem_we_o,
    output mem_addr_t   data_mem_addr_o,
    output logic [31:0] data_mem_din_o
);
    logic        core_enable;
    logic        core_clear;
    logic        start;
    mem_addr_t   initial_pc;
    logic [31:0] final_value;

    logic        fetch_req;
    mem_addr_t   fetch_addr;
    logic        fetch_gnt;
    logic        fetch_rvalid;
    logic [31:0] fetch_rdata;

    run_ctrl i_run_ctrl (
        .clk            (clk),
        .reset          (reset),
        .ctrl_i         (ctrl_i),
        .initial_pc_i   (initial_pc_i),
        .success_code_i (success_code_i),
        .final_value_i  (final_value),
        .core_enable_o  (core_enable),
        .core_clear_o   (core_clear),
        .start_o        (start),
        .initial_pc_o   (initial_pc),
        .stop_o         (stop_o)
    );

    rv_core i_core (
        .clk             (clk),
        .reset           (reset),
        .enable_i        (core_enable),
        .clear_i         (core_clear),
        .start_i         (start),
        .initial_pc_i    (initial_pc),
        .memory_offset_i (memory_offset_i),
        .fetch_gnt_i     (fetch_gnt),
        .fetch_rvalid_i  (fetch_rvalid),
        .fetch_rdata_i   (fetch_rdata),
        .fetch_req_o     (fetch_req),
        .fetch_addr_o    (fetch_addr),
        .final_value_o   (final_value),
        .data_mem_clk_o  (data_mem_clk_o),
        .data_mem_en_o   (data_mem_en_o),
        .data_mem_we_o   (data_mem_we_o),
        .data_mem_addr_o (data_mem_addr_o),
        .data_mem_din_o  (data_mem_din_o)
    );

    imem_bram_adapter i_imem_adapter (
        .clk            (clk),
        .reset          (reset),
        .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),
        .ins_mem_dout_i (ins_mem_dout_i),
        .fetch_gnt_o    (fetch_gnt),
        .fetch_rvalid_o (fetch_rvalid),
        .fetch_rdata_o  (fetch_rdata),
        .ins_mem_clk_o  (ins_mem_clk_o),
        .ins_mem_en_o   (ins_mem_en_o),
        .ins_mem_addr_o (ins_mem_addr_o)
    );

endmodule

// File: test/tb_rv_soc_top.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module tb_rv_soc_top import rv_isa_pkg::*, rv_mem_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 8;
    localparam int NUM_TESTS    = 6;
    localparam int RANDOM_LEN   = 24;
    // setup, dependent chain and success tail around the random part
    localparam int PROG_LEN     = RANDOM_LEN + 10;
    localparam int DMEM_BYTES   = 256;

    localparam int K_ADD   = 0;
    localparam int K_SUB   = 1;
    localparam int K_ADDI  = 2;
    localparam int K_LUI   = 3;
    localparam int K_SB    = 4;
    localparam int K_SH    = 5;
    localparam int K_SW    = 6;
    localparam int K_OTHER = 7;

    logic        clk;
    logic        reset;
    ctrl_word_t  ctrl_i;
    mem_addr_t   memory_offset_i;
    mem_addr_t   initial_pc_i;
    word_t       success_code_i;
    logic        stop_o;
    logic        ins_mem_clk_o;
    logic        ins_mem_en_o;
    mem_addr_t   ins_mem_addr_o;
    instr_t      ins_mem_dout_i;
    logic        data_mem_clk_o;
    logic        data_mem_en_o;
    byte_en_t    data_mem_we_o;
    mem_addr_t   data_mem_addr_o;
    word_t       data_mem_din_o;

    instr_t     prog_q[$];
    mem_addr_t  prog_base;
    mem_addr_t  data_offset;
    word_t      run_code;
    word_t      model_regs [`REG_COUNT];
    logic [7:0] model_mem [DMEM_BYTES];
    logic [7:0] dmem [DMEM_BYTES];
    mem_addr_t  exp_addr_q[$];
    byte_en_t   exp_be_q[$];
    word_t      exp_data_q[$];
    string      test_name;
    int         error_count;
    int         pass_count;
    int         cycle = 0;
    int         success_cycle;
    bit         quiet;

    rv_soc_top i_dut (
        .clk             (clk),
        .reset           (reset),
        .ctrl_i          (ctrl_i),
        .memory_offset_i (memory_offset_i),
        .initial_pc_i    (initial_pc_i),
        .success_code_i  (success_code_i),
        .stop_o          (stop_o),
        .ins_mem_clk_o   (ins_mem_clk_o),
        .ins_mem_en_o    (ins_mem_en_o),
        .ins_mem_addr_o  (ins_mem_addr_o),
        .ins_mem_dout_i  (ins_mem_dout_i),
        .data_mem_clk_o  (data_mem_clk_o),
        .data_mem_en_o   (data_mem_en_o),
        .data_mem_we_o   (data_mem_we_o),
        .data_mem_addr_o (data_mem_addr_o),
        .data_mem_din_o  (data_mem_din_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s: %s", test_name, msg);
        error_count++;
    endtask

    // program image with nops all around it
    function automatic instr_t rom_word(mem_addr_t addr);
        if (addr >= prog_base && addr < prog_base + 4 * prog_q.size()) begin
            return prog_q[(addr - prog_base) >> 2];
        end
        return `NOP_INSTR;
    endfunction

    // instruction bram with one cycle of read latency
    always @(posedge ins_mem_clk_o) begin : rom_read
        logic      rd_en;
        mem_addr_t rd_addr;
        rd_en   = ins_mem_en_o;
        rd_addr = ins_mem_addr_o;
        #1;
        if (rd_en) begin
            ins_mem_dout_i = rom_word(rd_addr);
        end
    end

    // data bram writes and store ordering
    always @(posedge data_mem_clk_o) begin : bus_monitor
        word_t mask;
        if (!reset) begin
            if (quiet && (ins_mem_en_o || data_mem_en_o || data_mem_we_o != 4'b0000)) begin
                report_error("fetch or data write while the core should be idle");
            end
            if (stop_o && (ins_mem_en_o || data_mem_we_o != 4'b0000)) begin
                report_error("fetch or data write after stop was raised");
            end
            if (stop_o && exp_addr_q.size() != 0) begin
                report_error("stop was raised before the success store");
            end
            if (data_mem_en_o && data_mem_we_o != 4'b0000) begin
                for (int i = 0; i < 4; i++) begin
                    if (data_mem_we_o[i]) begin
                        dmem[(data_mem_addr_o + i) % DMEM_BYTES] = data_mem_din_o[8*i +: 8];
                    end
                end
                if (exp_addr_q.size() == 0) begin
                    report_error("store seen with no store left in the program");
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        mask[8*i +: 8] = {8{exp_be_q[0][i]}};
                    end
                    check("store address", exp_addr_q[0], data_mem_addr_o);
                    check("store byte enable", exp_be_q[0], data_mem_we_o);
                    check("store data", exp_data_q[0] & mask, data_mem_din_o & mask);
                    void'(exp_addr_q.pop_front());
                    void'(exp_be_q.pop_front());
                    void'(exp_data_q.pop_front());
                    if (exp_addr_q.size() == 0) begin
                        success_cycle = cycle;
                    end
                end
            end
        end
    end

    function automatic word_t sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // lane placement of a store as a byte-addressed bus sees it
    task automatic record_store(input funct3_t f3, input mem_addr_t addr, input word_t value);
        int       nbytes;
        int       first;
        byte_en_t be;
        word_t    lanes;
        case (f3)
            3'b000: begin
                nbytes = 1;
            end
            3'b001: begin
                nbytes = 2;
            end
            default: begin
                nbytes = 4;
            end
        endcase
        // first byte lane of a naturally aligned access
        first = addr[1:0];
        first = first & ~(nbytes - 1);
        lanes = value << (8 * first);
        for (int i = 0; i < 4; i++) begin
            be[i] = (i >= first) && (i < first + nbytes);
            if (be[i]) begin
                model_mem[{addr[7:2], i[1:0]}] = lanes[8*i +: 8];
            end
        end
        exp_addr_q.push_back(addr & ~32'h3);
        exp_be_q.push_back(be);
        exp_data_q.push_back(lanes);
    endtask

    // encode one instruction and step the reference model
    task automatic add_instr(input int kind, input reg_idx_t rd, input reg_idx_t rs1,
                             input reg_idx_t rs2, input logic [19:0] imm);
        instr_t  instr;
        word_t   a;
        word_t   b;
        word_t   v;
        funct3_t f3;
        bit      writes;
        a      = model_regs[rs1];
        b      = model_regs[rs2];
        v      = '0;
        writes = 1'b1;
        case (kind)
            K_ADD: begin
                instr = {7'b0000000, rs2, rs1, 3'b000, rd, `OPC_OP};
                v     = a + b;
            end
            K_SUB: begin
                instr = {7'b0100000, rs2, rs1, 3'b000, rd, `OPC_OP};
                v     = a - b;
            end
            K_ADDI: begin
                instr = {imm[11:0], rs1, 3'b000, rd, `OPC_OP_IMM};
                v     = a + sext12(imm[11:0]);
            end
            K_LUI: begin
                instr = {imm, rd, `OPC_LUI};
                v     = {imm, 12'b0};
            end
            K_SB, K_SH, K_SW: begin
                f3     = (kind == K_SB) ? 3'b000 : (kind == K_SH) ? 3'b001 : 3'b010;
                instr  = {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
                writes = 1'b0;
                record_store(f3, a + sext12(imm[11:0]) - data_offset, b);
            end
            default: begin
                // xori is outside the subset
                instr  = {imm[11:0], rs1, 3'b100, rd, `OPC_OP_IMM};
                writes = 1'b0;
            end
        endcase
        if (writes && rd != '0) begin
            model_regs[rd] = v;
        end
        prog_q.push_back(instr);
    endtask

    task automatic load_value(input reg_idx_t rd, input word_t value);
        word_t upper;
        upper = value + 32'h800;
        add_instr(K_LUI, rd, 0, 0, upper[31:12]);
        add_instr(K_ADDI, rd, rd, 0, {8'b0, value[11:0]});
    endtask

    // small register pool so that dependencies come up often
    task automatic add_random_instr();
        int          kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [19:0] imm;
        kind = $urandom % (K_OTHER + 1);
        rd   = 2 + $urandom % 6;
        rs1  = 2 + $urandom % 6;
        rs2  = $urandom % 8;
        imm  = $urandom;
        // x1 holds the data offset so stores stay inside the bram
        case (kind)
            K_SB: begin
                rs1 = 1;
                imm = $urandom % DMEM_BYTES;
            end
            K_SH: begin
                rs1 = 1;
                imm = ($urandom % (DMEM_BYTES / 2)) * 2;
            end
            K_SW: begin
                rs1 = 1;
                imm = ($urandom % (DMEM_BYTES / 4)) * 4;
            end
            default: begin
            end
        endcase
        add_instr(kind, rd, rs1, rs2, imm);
    endtask

    task automatic build_program(input bit match);
        prog_q.delete();
        exp_addr_q.delete();
        exp_be_q.delete();
        exp_data_q.delete();
        prog_base   = $urandom & 32'h0000_fffc;
        data_offset = $urandom & 32'hffff_fffc;
        run_code    = $urandom | 32'h1;
        load_value(1, data_offset);
        // dependent chain at distances 1, 2 and 3
        add_instr(K_ADDI, 2, 0, 0, $urandom);
        add_instr(K_LUI, 3, 0, 0, $urandom);
        add_instr(K_ADD, 4, 2, 3, 0);
        add_instr(K_SUB, 5, 4, 2, 0);
        add_instr(K_SW, 0, 1, 5, 0);
        repeat (RANDOM_LEN) begin
            add_random_instr();
        end
        load_value(8, match ? run_code : run_code + 1);
        add_instr(K_SW, 0, 1, 8, ($urandom % (DMEM_BYTES / 4)) * 4);
    endtask

    task automatic soft_reset();
        ctrl_i = 32'h2;
        next_cycle();
        ctrl_i = 32'h0;
        repeat (2) next_cycle();
        quiet = 1'b1;
        repeat (3) next_cycle();
    endtask

    task automatic run_program(input int idx, input bit match);
        int start_errors;
        int waited;
        int stores;
        test_name    = $sformatf("prog%0d", idx);
        start_errors = error_count;
        build_program(match);
        stores          = exp_addr_q.size();
        initial_pc_i    = prog_base;
        memory_offset_i = data_offset;
        success_code_i  = run_code;
        next_cycle();
        quiet  = 1'b0;
        ctrl_i = 32'h1;
        next_cycle();
        ctrl_i = 32'h0;
        waited = 0;
        while (exp_addr_q.size() != 0 && waited < PROG_LEN + 20) begin
            next_cycle();
            waited++;
        end
        if (exp_addr_q.size() != 0) begin
            report_error($sformatf("%0d stores never reached the data port", exp_addr_q.size()));
        end
        if (match) begin
            while (!stop_o && cycle - success_cycle <= `SUCCESS_HOLD_CYCLES + 10) begin
                next_cycle();
            end
            check("stop_o", 1, stop_o);
            repeat (4) next_cycle();
        end else begin
            repeat (`SUCCESS_HOLD_CYCLES + 5) begin
                next_cycle();
                check("stop_o", 0, stop_o);
            end
        end
        for (int i = 0; i < DMEM_BYTES; i++) begin
            check($sformatf("data byte %0d", i), model_mem[i], dmem[i]);
        end
        soft_reset();
        if (error_count == start_errors) begin
            pass_count++;
        end
        $display("%s: %s, %0d stores, %0d errors", test_name,
                 (error_count == start_errors) ? "ok" : "bad", stores, error_count - start_errors);
    endtask

    initial begin
        void'($urandom(32'haf83aa5c));
        reset           = 1'b1;
        ctrl_i          = '0;
        memory_offset_i = '0;
        initial_pc_i    = '0;
        success_code_i  = '0;
        ins_mem_dout_i  = `NOP_INSTR;
        prog_base       = '0;
        data_offset     = '0;
        quiet           = 1'b1;
        error_count     = 0;
        pass_count      = 0;
        success_cycle   = 0;
        test_name       = "reset";
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset     = 1'b0;
        test_name = "idle";
        repeat (IDLE_CYCLES) next_cycle();
        // prog3 builds a value other than the success code
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_program(t, t != 3);
        end
        $display("summary: %0d of %0d tests ok, %0d errors", pass_count, NUM_TESTS, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + IDLE_CYCLES + NUM_TESTS * (PROG_LEN + 60)) @(posedge clk);
        $display("ERROR %s: timeout, the run did not finish in time", test_name);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_mem_pkg.sv
logic/rv_decode.sv
logic/rv_reg_file.sv
logic/rv_core.sv
logic/run_ctrl.sv
logic/imem_bram_adapter.sv
logic/rv_soc_top.sv
test/tb_rv_soc_top.sv

// File: Bender.yml
package:
  name: rv_soc

export_include_dirs:
  - logic

sources:
  - logic/rv_isa_pkg.sv
  - logic/rv_mem_pkg.sv
  - logic/rv_decode.sv
  - logic/rv_reg_file.sv
  - logic/rv_core.sv
  - logic/run_ctrl.sv
  - logic/imem_bram_adapter.sv
  - logic/rv_soc_top.sv
  - target: test
    files:
      - test/tb_rv_soc_top.sv
